// ==== tb.f ====
source/fetch_pkg.sv
source/fetch_if.sv
source/instr_rom.sv
source/ifetch.sv
source/branch_resolve.sv
source/fetch_top.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== sim/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

    localparam int PROG_LEN = 20;
    localparam int NROWS    = 20;
    localparam int RST_CYC  = 5;
    // Sum of load, reset hold, table and margin
    localparam int MAX_CYC  = PROG_LEN + 1 + RST_CYC + NROWS + 20;
    localparam logic [15:0] NONE = 16'hffff;

    // Program where sequential words carry their own address
    localparam logic [15:0] PROG [PROG_LEN] = '{
        16'h0000, 16'h0801, 16'h0802, 16'h1803,
        16'h0804, 16'h0805, 16'h0806, 16'h0807,
        16'h1802, 16'h0809, 16'h2000, 16'h080b,
        16'h080c, 16'h080d, 16'h080e, 16'h080f,
        16'h0810, 16'h0811, 16'h17fa, 16'h0813
    };

    // One cycle per row with stall, zero flag, JR target and retired PC
    localparam logic [33:0] ROWS [NROWS] = '{
        // Reset-state cycle then first fetch
        {1'b0, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd0},
        {1'b0, 1'b0, 16'h00ff, 16'd1},
        {1'b0, 1'b0, 16'h00ff, 16'd2},
        // Taken BZ +3 at 3 goes to 7
        {1'b0, 1'b1, 16'h00ff, 16'd3},
        {1'b0, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd7},
        // Stall with BZ at 8 in decode
        {1'b1, 1'b1, 16'h00ff, NONE},
        {1'b1, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd8},
        {1'b0, 1'b0, 16'h00ff, 16'd9},
        // JR at 10 to 16
        {1'b0, 1'b0, 16'h0010, 16'd10},
        {1'b0, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd16},
        {1'b1, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd17},
        // JMP -6 at 18 goes back to 13
        {1'b0, 1'b0, 16'h00ff, 16'd18},
        {1'b0, 1'b0, 16'h00ff, NONE},
        {1'b0, 1'b0, 16'h00ff, 16'd13}
    };

    logic                          CLK;
    logic                          RST;
    logic                          stall;
    logic                          zero_flag;
    logic [fetch_pkg::XLEN-1:0]    jr_target;
    logic                          wr_en;
    logic [fetch_pkg::IMEM_AW-1:0] wr_addr;
    logic [fetch_pkg::XLEN-1:0]    wr_data;
    logic [fetch_pkg::XLEN-1:0]    exp_pc;
    logic [fetch_pkg::XLEN-1:0]    pc;
    logic [fetch_pkg::XLEN-1:0]    instr;
    logic [fetch_pkg::XLEN-1:0]    epc;
    logic                          valid;
    logic                          redirect;
    int                            cycles;
    int                            errors;
    int                            rows_done;

    fetch_top dut0 (
        .CLK (CLK), .RST (RST), .stall_i (stall), .zero_flag_i (zero_flag),
        .jr_target_i (jr_target), .wr_en_i (wr_en), .wr_addr_i (wr_addr),
        .wr_data_i (wr_data), .pc_o (pc), .instr_o (instr), .valid_o (valid),
        .epc_o (epc), .redirect_o (redirect)
    );

    fetch_checker chk0 (
        .CLK (CLK), .RST (RST), .stall_i (stall), .zero_flag_i (zero_flag),
        .jr_target_i (jr_target), .exp_pc_i (exp_pc), .wr_en_i (wr_en),
        .wr_addr_i (wr_addr), .wr_data_i (wr_data), .pc_i (pc), .instr_i (instr),
        .epc_i (epc), .valid_i (valid), .redirect_i (redirect),
        .err_cnt_o (errors), .row_cnt_o (rows_done)
    );

    //////////////////////////////////////////////////
    // Clock and run limit
    //////////////////////////////////////////////////

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYC) begin
            $display("Timeout: stimulus table did not finish within %0d cycles", MAX_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        cycles    = 0;
        RST       = 1'b0;
        stall     = 1'b0;
        zero_flag = 1'b0;
        jr_target = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        exp_pc    = NONE;
        // Program load while held in reset
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge CLK);
            #5;
            wr_en   = 1'b1;
            wr_addr = i[7:0];
            wr_data = PROG[i];
        end
        @(posedge CLK);
        #5;
        wr_en = 1'b0;
        repeat (RST_CYC) @(posedge CLK);
        #5;
        RST = 1'b1;
        // One row per cycle 5 ns after the edge
        for (int k = 0; k < NROWS; k++) begin
            {stall, zero_flag, jr_target, exp_pc} = ROWS[k];
            @(posedge CLK);
            #5;
        end
        $display("Rows checked %0d of %0d, failed checks %0d", rows_done, NROWS, errors);
        if (errors == 0 && rows_done == NROWS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/fetch_checker.sv ====
`timescale 1ns/10ps

module fetch_checker (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          stall_i,
    input  logic                          zero_flag_i,
    input  logic [fetch_pkg::XLEN-1:0]    jr_target_i,
    input  logic [fetch_pkg::XLEN-1:0]    exp_pc_i,
    input  logic                          wr_en_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] wr_addr_i,
    input  logic [fetch_pkg::XLEN-1:0]    wr_data_i,
    input  logic [fetch_pkg::XLEN-1:0]    pc_i,
    input  logic [fetch_pkg::XLEN-1:0]    instr_i,
    input  logic [fetch_pkg::XLEN-1:0]    epc_i,
    input  logic                          valid_i,
    input  logic                          redirect_i,
    output int                            err_cnt_o,
    output int                            row_cnt_o
);

    // Table marker for a cycle that retires nothing
    localparam logic [15:0] NO_RET = 16'hffff;

    // Shadow of the loaded program
    logic [15:0] gmem [fetch_pkg::IMEM_DEPTH];

    // Golden fetch and decode state
    logic        f_live;
    logic [15:0] f_pc;
    logic        d_valid;
    logic [15:0] d_pc;
    logic [15:0] d_instr;
    logic [4:0]  op;
    logic        d_br;
    logic        redir;
    logic [15:0] nxt;
    logic [15:0] ret_pc;
    int          row_errs;

    // Branch or jump target as its own PC + 1 + signed offset
    function automatic logic [15:0] branch_target(input logic [15:0] pc, input logic [15:0] w);
        logic [15:0] off;
        if (w[15:11] == fetch_pkg::OP_JMP) begin
            off = {{5{w[10]}}, w[10:0]};
        end else begin
            off = {{8{w[7]}}, w[7:0]};
        end
        return pc + 16'd1 + off;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            $display("Fail %s row %0d exp %h got %h", name, row_cnt_o, exp, got);
            row_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // Model step and compare at mid-cycle
    //////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (!RST) begin
            f_live    = 1'b0;
            f_pc      = '0;
            d_valid   = 1'b0;
            err_cnt_o = 0;
            row_cnt_o = 0;
            // Mirror the load port
            if (wr_en_i) begin
                gmem[wr_addr_i] = wr_data_i;
            end
        end else begin
            row_errs = 0;
            op       = d_instr[15:11];
            d_br     = d_valid && (op == fetch_pkg::OP_JMP || op == fetch_pkg::OP_BZ
                                   || op == fetch_pkg::OP_JR);
            // Not-taken prediction means a taken branch redirects
            redir = 1'b0;
            nxt   = f_pc + 16'd1;
            if (!stall_i && d_valid && op == fetch_pkg::OP_JR) begin
                redir = 1'b1;
                nxt   = jr_target_i;
            end else if (!stall_i && d_valid && (op == fetch_pkg::OP_JMP
                         || (op == fetch_pkg::OP_BZ && zero_flag_i))) begin
                redir = 1'b1;
                nxt   = branch_target(d_pc, d_instr);
            end
            ret_pc = (d_valid && !stall_i) ? d_pc : NO_RET;
            if (exp_pc_i !== ret_pc) begin
                $display("Row %0d: table expects retired PC %h but the model retires %h",
                         row_cnt_o, exp_pc_i, ret_pc);
                row_errs++;
            end
            check_value("valid_o", {15'd0, ret_pc != NO_RET}, {15'd0, valid_i});
            // Decode word also held through stall
            if (d_valid) begin
                check_value("pc_o", d_pc, pc_i);
                check_value("instr_o", d_instr, instr_i);
            end
            // Branch PC while one sits in decode
            check_value("epc_o", d_br ? d_pc : f_pc, epc_i);
            check_value("redirect_o", {15'd0, redir}, {15'd0, redirect_i});
            if (row_errs == 0) begin
                $display("Row %0d pass", row_cnt_o);
            end
            err_cnt_o += row_errs;
            row_cnt_o++;
            // Advance to the state after the next edge
            if (!stall_i) begin
                if (!f_live) begin
                    f_live  = 1'b1;
                    f_pc    = '0;
                    d_valid = 1'b0;
                end else begin
                    d_valid = !redir;
                    d_pc    = f_pc;
                    d_instr = (f_pc[15:8] == 8'h00) ? gmem[f_pc[7:0]] : '0;
                    f_pc    = nxt;
                end
            end
        end
    end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          stall_i,
    input  logic                          zero_flag_i,
    input  logic [fetch_pkg::XLEN-1:0]    jr_target_i,
    input  logic                          wr_en_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] wr_addr_i,
    input  logic [fetch_pkg::XLEN-1:0]    wr_data_i,
    output logic [fetch_pkg::XLEN-1:0]    pc_o,
    output logic [fetch_pkg::XLEN-1:0]    instr_o,
    output logic                          valid_o,
    output logic [fetch_pkg::XLEN-1:0]    epc_o,
    output logic                          redirect_o
);

    // Fetch to decode bundle
    fetch_if fi ();

    logic [fetch_pkg::XLEN-1:0] fetch_pc;
    logic [fetch_pkg::XLEN-1:0] fetch_instr;

    // Resolve back to fetch
    logic isbranch;
    logic jr;
    logic prewrong;

    assign redirect_o = jr || prewrong;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    instr_rom rom0 (
        .CLK       (CLK),
        .RST       (RST),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_addr_i (fetch_pc),
        .rd_data_o (fetch_instr)
    );

    ifetch if0 (
        .CLK          (CLK),
        .RST          (RST),
        .stall_i      (stall_i),
        .jr_i         (jr),
        .isbranch_i   (isbranch),
        .prewrong_i   (prewrong),
        .address_jr_i (jr_target_i),
        .instr_i      (fetch_instr),
        .pc_o         (fetch_pc),
        .epc_o        (epc_o),
        .f_o          (fi.fetch)
    );

    branch_resolve br0 (
        .CLK         (CLK),
        .RST         (RST),
        .stall_i     (stall_i),
        .zero_flag_i (zero_flag_i),
        .f_i         (fi.decode),
        .isbranch_o  (isbranch),
        .jr_o        (jr),
        .prewrong_o  (prewrong),
        .valid_o     (valid_o),
        .instr_o     (instr_o),
        .pc_o        (pc_o)
    );

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/10ps

module branch_resolve (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       stall_i,
    input  logic                       zero_flag_i,
    fetch_if.decode                    f_i,
    output logic                       isbranch_o,
    output logic                       jr_o,
    output logic                       prewrong_o,
    output logic                       valid_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o
);

    // Decode pipeline register
    fetch_pkg::fetch_bundle_t dec_q;
    logic                     dec_valid;

    logic [fetch_pkg::OP_W-1:0] op;
    logic                       is_jmp;
    logic                       is_bz;
    logic                       is_jr;
    logic                       taken;
    logic                       redirect;

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////

    assign op = dec_q.instr[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB];

    assign is_jmp = (op == fetch_pkg::OP_JMP);
    assign is_bz  = (op == fetch_pkg::OP_BZ);
    assign is_jr  = (op == fetch_pkg::OP_JR);

    // Not-taken prediction, so any taken JMP/BZ is a miss
    assign taken = is_jmp || (is_bz && zero_flag_i);

    // Branch flag stays up through stall so epc holds
    assign isbranch_o = dec_valid && (is_jmp || is_bz || is_jr);

    // Redirects only on a moving pipeline
    assign jr_o       = dec_valid && is_jr && !stall_i;
    assign prewrong_o = dec_valid && taken && !stall_i;

    assign redirect = jr_o || prewrong_o;

    //////////////////////////////////////////////////
    // Retire view
    //////////////////////////////////////////////////

    assign valid_o = dec_valid && !stall_i;
    assign instr_o = dec_q.instr;
    assign pc_o    = dec_q.pc;

    // Valid bit, reset and flush
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            dec_valid <= 1'b0;
        end else if (!stall_i) begin
            // Word fetched under a redirect is dropped
            dec_valid <= f_i.valid && !redirect;
        end
    end

    // Payload, no reset
    always_ff @(posedge CLK) begin
        if (!stall_i) begin
            dec_q <= f_i.bundle;
        end
    end

    // Stall and redirect never meet at ifetch
    a_no_redirect_on_stall: assert property (@(posedge CLK) disable iff (!RST)
        stall_i |-> !(jr_o || prewrong_o));

    // Without a redirect the next word is the fall-through
    a_seq_flow: assert property (@(posedge CLK) disable iff (!RST)
        !stall_i && dec_valid && f_i.valid && !redirect
        |-> f_i.bundle.pc == dec_q.pcplus1);

endmodule

// ==== source/ifetch.sv ====
`timescale 1ns/10ps

module ifetch (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       stall_i,
    input  logic                       jr_i,
    input  logic                       isbranch_i,
    input  logic                       prewrong_i,
    input  logic [fetch_pkg::XLEN-1:0] address_jr_i,
    input  logic [fetch_pkg::XLEN-1:0] instr_i,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] epc_o,
    fetch_if.fetch                     f_o
);

    // Program counter and reset-state flag
    logic [fetch_pkg::XLEN-1:0] pc;
    logic                       reset_pend;

    // Copies of the word now sitting in decode
    logic [fetch_pkg::XLEN-1:0] pc_lock;
    logic [fetch_pkg::XLEN-1:0] pcplus1_lock;
    logic [fetch_pkg::XLEN-1:0] target_lock;

    logic [fetch_pkg::XLEN-1:0] ext_off;
    logic [fetch_pkg::XLEN-1:0] pcplus1;
    logic [fetch_pkg::XLEN-1:0] target;
    logic [fetch_pkg::XLEN-1:0] next_pc;

    //////////////////////////////////////////////////
    // Offset and next PC
    //////////////////////////////////////////////////

    // JMP carries the long offset, everything else the short one
    always_comb begin
        if (instr_i[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB] == fetch_pkg::OP_JMP) begin
            ext_off = {{(fetch_pkg::XLEN - fetch_pkg::JMP_OFF_W){instr_i[10]}},
                       instr_i[fetch_pkg::JMP_OFF_W-1:0]};
        end else begin
            ext_off = {{(fetch_pkg::XLEN - fetch_pkg::BZ_OFF_W){instr_i[7]}},
                       instr_i[fetch_pkg::BZ_OFF_W-1:0]};
        end
    end

    assign pcplus1 = pc + 16'h0001;
    // Computed every cycle, only kept for branches
    assign target  = pcplus1 + ext_off;

    // Register jump wins, then the mispredicted branch
    assign next_pc = jr_i       ? address_jr_i :
                     prewrong_i ? target_lock  :
                                  pcplus1;

    // Controlling instruction while a branch is in decode
    assign epc_o = isbranch_i ? pc_lock : pc;
    assign pc_o  = pc;

    //////////////////////////////////////////////////
    // To decode
    //////////////////////////////////////////////////

    assign f_o.bundle.instr   = instr_i;
    assign f_o.bundle.pc      = pc;
    assign f_o.bundle.pcplus1 = pcplus1;
    assign f_o.valid          = !reset_pend;

    // PC and lock registers, all frozen by stall
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            reset_pend <= 1'b1;
            pc         <= '0;
        end else if (!stall_i) begin
            if (reset_pend) begin
                // Reset-state cycle
                pc         <= '0;
                reset_pend <= 1'b0;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // Payload copies, no reset
    always_ff @(posedge CLK) begin
        if (!stall_i && !reset_pend) begin
            pc_lock      <= pc;
            pcplus1_lock <= pcplus1;
            target_lock  <= target;
        end
    end

    // Stall holds the PC across the edge
    a_pc_hold: assert property (@(posedge CLK) disable iff (!RST)
        stall_i |=> pc == $past(pc));

    // Decode never flags both redirect kinds
    a_jr_excl: assert property (@(posedge CLK) disable iff (!RST)
        !(jr_i && prewrong_i));

    // Fetch sits on the fall-through of a branch that stays
    a_fallthrough: assert property (@(posedge CLK) disable iff (!RST)
        isbranch_i && !jr_i && !prewrong_i |-> pc == pcplus1_lock);

endmodule

// ==== source/instr_rom.sv ====
`timescale 1ns/10ps

module instr_rom (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          wr_en_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] wr_addr_i,
    input  logic [fetch_pkg::XLEN-1:0]    wr_data_i,
    input  logic [fetch_pkg::XLEN-1:0]    rd_addr_i,
    output logic [fetch_pkg::XLEN-1:0]    rd_data_o
);

    // Word array
    logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::IMEM_DEPTH];

    logic rd_in_range;

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Upper PC bits beyond the array
    assign rd_in_range = (rd_addr_i < fetch_pkg::IMEM_DEPTH);

    // Same-cycle read, zero past the end
    assign rd_data_o = rd_in_range ? mem[rd_addr_i[fetch_pkg::IMEM_AW-1:0]] : '0;

    //////////////////////////////////////////////////
    // Load port
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Loading happens with the pipeline held in reset
    // and only to known, in-range addresses
    a_wr_range: assert property (@(posedge CLK)
        wr_en_i |-> !RST && !$isunknown(wr_addr_i)
                    && (wr_addr_i < fetch_pkg::IMEM_DEPTH));

endmodule

// ==== source/fetch_if.sv ====
`timescale 1ns/10ps

// Fetch to decode transfer
// Word is taken on any cycle without stall, no handshake
interface fetch_if;

    // Fetched word, its PC and fall-through PC
    fetch_pkg::fetch_bundle_t bundle;

    // Low in the reset-state cycle
    logic valid;

    // Producer side, the fetch stage
    modport fetch (
        output bundle,
        output valid
    );

    // Consumer side, the decode register
    modport decode (
        input bundle,
        input valid
    );

endinterface

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////////////////////////
    // Widths and memory geometry
    //////////////////////////////////////////////////

    // Machine word, also the PC width
    localparam int XLEN       = 16;

    // Instruction memory, word addressed
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;

    // Opcode field position
    localparam int OP_MSB     = 15;
    localparam int OP_LSB     = 11;
    localparam int OP_W       = OP_MSB - OP_LSB + 1;

    // Offset widths per branch flavour
    localparam int JMP_OFF_W  = 11;
    localparam int BZ_OFF_W   = 8;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    // Unconditional, offset in bits 10..0
    localparam logic [OP_W-1:0] OP_JMP = 5'b00010;
    // Taken on zero flag, offset in bits 7..0
    localparam logic [OP_W-1:0] OP_BZ  = 5'b00011;
    // Register jump, target from outside
    localparam logic [OP_W-1:0] OP_JR  = 5'b00100;

    // One fetched word with its addresses
    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcplus1;
    } fetch_bundle_t;

endpackage
